//--- Makefile
# Verilator build and run for the SoC testbench

VERILATOR ?= verilator
TOP       ?= soc_system_tb
FILELIST  ?= soc_system.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/bus_interconnect.sv
`timescale 1ns/1ps

module bus_interconnect
   import soc_pkg::*;
(
   input  region_t                region,
   input  logic                   boot,
   input  logic                   m_valid,
   output bus_rsp_t               m_rsp,
   output logic [N_SLAVES-1:0]    s_valid,
   input  bus_rsp_t               s_rsp [N_SLAVES]
);

   region_t             sel;
   logic [N_SLAVES-1:0] s_ready;

   // while booting, the firmware window points at the boot RAM
   always_comb begin
      if (boot && region == REGION_FW) begin
         sel = REGION_BOOT;
      end else begin
         sel = region;
      end
   end

   always_comb begin
      s_valid      = '0;
      s_valid[sel] = m_valid;
   end

   // only the addressed slave answers
   always_comb begin
      m_rsp = s_rsp[sel];
   end

   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_ready[i] = s_rsp[i].ready;
      end
   end

   // a second answering slave would be hidden by the mux
   always_comb begin
      assert final ($onehot0(s_ready))
         else $error("more than one slave ready: %b", s_ready);
   end

endmodule

//--- rtl/reset_ctrl.sv
`timescale 1ns/1ps

module reset_ctrl
   import soc_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     valid,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     boot,
   output logic     core_reset
);

   logic ready;
   logic soft_reset;
   logic access;

   assign access = valid && !ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready      <= 1'b0;
         boot       <= 1'b1;
         soft_reset <= 1'b0;
      end else begin
         ready      <= access;
         soft_reset <= 1'b0;
         // bit 0 kicks the core, bit 1 selects boot mode
         if (access && req.wstrb != '0) begin
            soft_reset <= req.wdata[0];
            boot       <= req.wdata[1];
         end
      end
   end

   assign core_reset = reset | soft_reset;

   assign rsp.ready = ready;
   assign rsp.rdata = {30'b0, boot, 1'b0};

endmodule

//--- rtl/soc_pkg.sv
package soc_pkg;

   // byte address and data word of the memory port
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;

   // all zero means a read
   typedef logic [3:0] strb_t;

   // top two address bits pick the slave
   typedef logic [1:0] region_t;

   localparam region_t REGION_FW   = 2'd0;
   localparam region_t REGION_BOOT = 2'd1;
   localparam region_t REGION_UART = 2'd2;
   localparam region_t REGION_RST  = 2'd3;

   localparam int N_SLAVES = 4;

   typedef struct packed {
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } bus_req_t;

   typedef struct packed {
      logic  ready;
      data_t rdata;
   } bus_rsp_t;

endpackage

//--- rtl/soc_system.sv
`timescale 1ns/1ps

module soc_system
   import soc_pkg::*;
#(
   parameter int BOOT_ADDR_W = 8,
   parameter int FW_ADDR_W   = 10,
   parameter int UART_DIV    = 16
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     m_valid,
   input  bus_req_t m_req,
   output bus_rsp_t m_rsp,
   output logic     core_reset,
   output logic     txd,
   input  logic     cts
);

   region_t             region;
   logic                boot;
   logic [N_SLAVES-1:0] s_valid;
   bus_rsp_t            s_rsp [N_SLAVES];

   assign region = m_req.addr[31:30];

   bus_interconnect i_bus_interconnect (
      .region  (region),
      .boot    (boot),
      .m_valid (m_valid),
      .m_rsp   (m_rsp),
      .s_valid (s_valid),
      .s_rsp   (s_rsp)
   );

   sram #(.ADDR_W(BOOT_ADDR_W)) boot_mem (
      .clk   (clk),
      .reset (reset),
      .valid (s_valid[REGION_BOOT]),
      .req   (m_req),
      .rsp   (s_rsp[REGION_BOOT])
   );

   sram #(.ADDR_W(FW_ADDR_W)) fw_mem (
      .clk   (clk),
      .reset (reset),
      .valid (s_valid[REGION_FW]),
      .req   (m_req),
      .rsp   (s_rsp[REGION_FW])
   );

   uart_tx_core #(.DEFAULT_DIV(UART_DIV)) i_uart_tx_core (
      .clk   (clk),
      .reset (reset),
      .valid (s_valid[REGION_UART]),
      .req   (m_req),
      .rsp   (s_rsp[REGION_UART]),
      .txd   (txd),
      .cts   (cts)
   );

   reset_ctrl i_reset_ctrl (
      .clk        (clk),
      .reset      (reset),
      .valid      (s_valid[REGION_RST]),
      .req        (m_req),
      .rsp        (s_rsp[REGION_RST]),
      .boot       (boot),
      .core_reset (core_reset)
   );

endmodule

//--- rtl/sram.sv
`timescale 1ns/1ps

module sram
   import soc_pkg::*;
#(
   parameter int ADDR_W = 8
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     valid,
   input  bus_req_t req,
   output bus_rsp_t rsp
);

   data_t              mem [2**ADDR_W];
   logic [ADDR_W-1:0]  word_addr;
   logic               ready;
   data_t              rdata;
   logic               access;

   // upper address bits fold back onto the array
   assign word_addr = req.addr[ADDR_W+1:2];
   assign access    = valid && !ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready <= 1'b0;
      end else begin
         ready <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b]) begin
               mem[word_addr][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
         rdata <= mem[word_addr];
      end
   end

   assign rsp.ready = ready;
   assign rsp.rdata = rdata;

   // one acknowledge per request
   assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
      else $error("sram ready held for two cycles");

endmodule

//--- rtl/uart_pkg.sv
package uart_pkg;

   // word offsets, address bits 3:2
   localparam logic [1:0] UART_TXDATA = 2'd0;
   localparam logic [1:0] UART_STATUS = 2'd1;
   localparam logic [1:0] UART_DIV    = 2'd2;

   // clock cycles per serial bit
   typedef logic [15:0] div_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

endpackage

//--- rtl/uart_tx_core.sv
`timescale 1ns/1ps

module uart_tx_core
   import soc_pkg::*, uart_pkg::*;
#(
   parameter int DEFAULT_DIV = 16
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     valid,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     txd,
   input  logic     cts
);

   tx_state_t   state;
   div_t        div;
   div_t        baud_cnt;
   logic [2:0]  bit_cnt;
   logic [7:0]  shift;
   logic        pending;
   logic        ready;
   data_t       rdata;
   logic [1:0]  offset;
   logic        access;
   logic        wr;
   logic        busy;
   logic        load;
   logic        bit_end;

   assign offset  = req.addr[3:2];
   assign access  = valid && !ready;
   assign wr      = access && (req.wstrb != '0);
   assign busy    = (state != TX_IDLE) || pending;
   // writes while busy get acked and dropped
   assign load    = wr && offset == UART_TXDATA && !busy;
   assign bit_end = (baud_cnt == div_t'(div - 16'd1));

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready    <= 1'b0;
         state    <= TX_IDLE;
         div      <= div_t'(DEFAULT_DIV);
         baud_cnt <= '0;
         bit_cnt  <= '0;
         pending  <= 1'b0;
      end else begin
         ready <= access;
         if (wr && offset == UART_DIV) begin
            div <= req.wdata[15:0];
         end
         // byte waits here until the receiver is ready
         if (load && !cts) begin
            pending <= 1'b1;
         end
         if (state != TX_IDLE) begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 16'd1;
         end
         case (state)
            TX_IDLE: begin
               if ((load || pending) && cts) begin
                  state    <= TX_START;
                  baud_cnt <= '0;
                  pending  <= 1'b0;
               end
            end
            TX_START: begin
               if (bit_end) begin
                  state   <= TX_DATA;
                  bit_cnt <= '0;
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  if (bit_cnt == 3'd7) begin
                     state <= TX_STOP;
                  end else begin
                     bit_cnt <= bit_cnt + 3'd1;
                  end
               end
            end
            TX_STOP: begin
               if (bit_end) begin
                  state <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         shift <= req.wdata[7:0];
      end else if (state == TX_DATA && bit_end) begin
         shift <= shift >> 1;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (offset)
            UART_STATUS: rdata <= {31'b0, busy};
            UART_DIV:    rdata <= {16'b0, div};
            default:     rdata <= '0;
         endcase
      end
   end

   // lsb first, line idles high
   always_comb begin
      case (state)
         TX_START: txd = 1'b0;
         TX_DATA:  txd = shift[0];
         default:  txd = 1'b1;
      endcase
   end

   assign rsp.ready = ready;
   assign rsp.rdata = rdata;

   assert property (@(posedge clk) disable iff (reset)
      $rose(state == TX_START) |-> $past(state == TX_IDLE))
      else $error("uart frame started while busy");

endmodule

//--- soc_system.f
rtl/soc_pkg.sv
rtl/uart_pkg.sv
rtl/bus_interconnect.sv
rtl/sram.sv
rtl/uart_tx_core.sv
rtl/reset_ctrl.sv
rtl/soc_system.sv
test/tb_clock.sv
test/soc_system_tb.sv

//--- test/soc_system_tb.sv
`timescale 1ns/1ps

module soc_system_tb
   import soc_pkg::*, uart_pkg::*;
();

   localparam int BOOT_ADDR_W   = 8;
   localparam int FW_ADDR_W     = 10;
   localparam int BAUD_DIV      = 16;
   localparam int BUS_TIMEOUT   = 20;
   localparam int UART_TIMEOUT  = 400;
   localparam int RESET_TIMEOUT = 20;

   localparam addr_t BOOT_BASE   = 32'h4000_0000;
   localparam addr_t UART_BASE   = 32'h8000_0000;
   localparam addr_t RST_BASE    = 32'hc000_0000;
   localparam addr_t TX_ADDR     = UART_BASE | {28'b0, UART_TXDATA, 2'b00};
   localparam addr_t STATUS_ADDR = UART_BASE | {28'b0, UART_STATUS, 2'b00};
   localparam addr_t DIV_ADDR    = UART_BASE | {28'b0, UART_DIV, 2'b00};

   logic     clk;
   logic     reset;
   logic     m_valid;
   bus_req_t m_req;
   bus_rsp_t m_rsp;
   logic     core_reset;
   logic     txd;
   logic     cts;

   integer     seed = 32'hd38b;
   logic       boot_flag;
   data_t      boot_shadow [2**BOOT_ADDR_W];
   data_t      fw_shadow [2**FW_ADDR_W];
   string      name_q [$];
   data_t      exp_q [$];
   data_t      act_q [$];
   string      chk_name;
   data_t      chk_exp;
   data_t      chk_act;
   addr_t      boot_addrs [$];
   addr_t      fw_addrs [$];
   addr_t      test_addr;
   data_t      read_word;
   data_t      word;
   strb_t      strb;
   logic [9:0] idx;
   logic [7:0] tx_byte;
   logic [7:0] rx_byte;
   int         pulses;
   int         reset_wait;

   tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(4)) i_tb_clock (
      .clk   (clk),
      .reset (reset)
   );

   soc_system #(
      .BOOT_ADDR_W (BOOT_ADDR_W),
      .FW_ADDR_W   (FW_ADDR_W),
      .UART_DIV    (BAUD_DIV)
   ) i_soc_system (
      .clk        (clk),
      .reset      (reset),
      .m_valid    (m_valid),
      .m_req      (m_req),
      .m_rsp      (m_rsp),
      .core_reset (core_reset),
      .txd        (txd),
      .cts        (cts)
   );

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic queue_check(input string name, input data_t expected, input data_t actual);
      name_q.push_back(name);
      exp_q.push_back(expected);
      act_q.push_back(actual);
   endtask

   // shadow model of the slaves
   function automatic region_t target_region(input addr_t addr);
      if (boot_flag && addr[31:30] == REGION_FW) begin
         return REGION_BOOT;
      end
      return addr[31:30];
   endfunction

   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input strb_t sel);
      data_t result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   function automatic void model_write(input addr_t addr, input data_t data, input strb_t sel);
      case (target_region(addr))
         REGION_FW: begin
            fw_shadow[addr[FW_ADDR_W+1:2]] =
               merge_bytes(fw_shadow[addr[FW_ADDR_W+1:2]], data, sel);
         end
         REGION_BOOT: begin
            boot_shadow[addr[BOOT_ADDR_W+1:2]] =
               merge_bytes(boot_shadow[addr[BOOT_ADDR_W+1:2]], data, sel);
         end
         REGION_RST: begin
            if (sel != '0) begin
               boot_flag = data[1];
            end
         end
         default: begin
         end
      endcase
   endfunction

   function automatic data_t expected_read(input addr_t addr);
      case (target_region(addr))
         REGION_FW:   return fw_shadow[addr[FW_ADDR_W+1:2]];
         REGION_BOOT: return boot_shadow[addr[BOOT_ADDR_W+1:2]];
         REGION_RST:  return {30'b0, boot_flag, 1'b0};
         default:     return '0;
      endcase
   endfunction

   // one request on the master port, caller sits on a falling edge
   task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                             output data_t rdata);
      int cycles;
      m_req.addr  = addr;
      m_req.wdata = wdata;
      m_req.wstrb = wstrb;
      m_valid     = 1'b1;
      cycles      = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (m_rsp.ready !== 1'b1 && cycles < BUS_TIMEOUT);
      if (m_rsp.ready !== 1'b1) begin
         stop_on_error($sformatf("no ready on the bus for address 0x%08h", addr));
      end
      assert (cycles == 1)
         else stop_on_error($sformatf("ready for address 0x%08h came after %0d cycles",
                                      addr, cycles));
      rdata       = m_rsp.rdata;
      m_valid     = 1'b0;
      m_req.wstrb = '0;
      // idle cycle before the next request
      @(negedge clk);
   endtask

   task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t wstrb);
      data_t unused;
      bus_access(addr, wdata, wstrb, unused);
   endtask

   task automatic bus_read(input addr_t addr, output data_t rdata);
      bus_access(addr, '0, '0, rdata);
   endtask

   task automatic check_read(input addr_t addr, input string name);
      data_t actual;
      bus_read(addr, actual);
      queue_check($sformatf("m_rsp.rdata %s", name), expected_read(addr), actual);
   endtask

   // samples txd in the middle of each bit
   task automatic uart_receive(input int div, output logic [7:0] data);
      int cycles;
      cycles = 0;
      while (txd !== 1'b0) begin
         @(negedge clk);
         cycles++;
         if (cycles > UART_TIMEOUT) begin
            stop_on_error($sformatf("no start bit on txd within %0d cycles", UART_TIMEOUT));
         end
      end
      repeat (div / 2) @(negedge clk);
      queue_check("txd start bit", 32'h0, {31'b0, txd});
      for (int i = 0; i < 8; i++) begin
         repeat (div) @(negedge clk);
         data[i] = txd;
      end
      repeat (div) @(negedge clk);
      queue_check("txd stop bit", 32'h1, {31'b0, txd});
   endtask

   task automatic wait_uart_idle();
      data_t status;
      int    reads;
      reads = 0;
      bus_read(STATUS_ADDR, status);
      while (status[0] !== 1'b0) begin
         reads++;
         if (reads > UART_TIMEOUT) begin
            stop_on_error("uart status stayed busy past the timeout");
         end
         bus_read(STATUS_ADDR, status);
      end
   endtask

   task automatic line_stays_idle(input int n);
      for (int c = 0; c < n; c++) begin
         @(negedge clk);
         queue_check("txd idle", 32'h1, {31'b0, txd});
      end
   endtask

   task automatic count_core_reset(input int window, output int count);
      count = 0;
      repeat (window) begin
         @(negedge clk);
         if (core_reset === 1'b1) begin
            count++;
         end
      end
   endtask

   task automatic send_byte(input logic [7:0] value, input int div);
      logic [7:0] received;
      fork
         uart_receive(div, received);
         bus_write(TX_ADDR, {24'b0, value}, 4'hf);
      join
      queue_check("txd frame", {24'b0, value}, {24'b0, received});
      wait_uart_idle();
   endtask

   // compare side
   always @(posedge clk) begin
      while (act_q.size() > 0) begin
         chk_name = name_q.pop_front();
         chk_exp  = exp_q.pop_front();
         chk_act  = act_q.pop_front();
         assert (chk_act === chk_exp)
            else stop_on_error($sformatf("ERROR %s expected 0x%08h actual 0x%08h",
                                         chk_name, chk_exp, chk_act));
      end
   end

   initial begin
      m_valid   = 1'b0;
      m_req     = '0;
      cts       = 1'b1;
      boot_flag = 1'b1;
      @(posedge clk);
      @(negedge clk);
      queue_check("core_reset", 32'h1, {31'b0, core_reset});
      queue_check("txd", 32'h1, {31'b0, txd});
      queue_check("m_rsp.ready", 32'h0, {31'b0, m_rsp.ready});
      reset_wait = 0;
      while (reset !== 1'b0) begin
         @(posedge clk);
         reset_wait++;
         if (reset_wait > RESET_TIMEOUT) begin
            stop_on_error("reset was not released in time");
         end
      end
      @(negedge clk);
      queue_check("core_reset", 32'h0, {31'b0, core_reset});
      check_read(RST_BASE, "boot flag");
      bus_read(DIV_ADDR, read_word);
      queue_check("m_rsp.rdata uart divisor", data_t'(BAUD_DIV), read_word);
      bus_read(STATUS_ADDR, read_word);
      queue_check("m_rsp.rdata uart status", 32'h0, read_word);

      // region 0 points at the boot RAM
      repeat (8) begin
         idx       = 10'($random(seed));
         test_addr = {20'b0, idx, 2'b00};
         word      = $random(seed);
         bus_write(test_addr, word, 4'hf);
         model_write(test_addr, word, 4'hf);
         boot_addrs.push_back(test_addr);
      end
      foreach (boot_addrs[i]) begin
         check_read(boot_addrs[i], "boot ram via region 0");
         check_read(boot_addrs[i] | BOOT_BASE, "boot ram via region 1");
      end

      bus_write(RST_BASE, 32'h0, 4'hf);
      model_write(RST_BASE, 32'h0, 4'hf);
      check_read(RST_BASE, "boot flag");
      repeat (8) begin
         idx       = 10'($random(seed));
         test_addr = {20'b0, idx, 2'b00};
         word      = $random(seed);
         bus_write(test_addr, word, 4'hf);
         model_write(test_addr, word, 4'hf);
         fw_addrs.push_back(test_addr);
      end
      foreach (fw_addrs[i]) begin
         check_read(fw_addrs[i], "fw ram via region 0");
      end
      foreach (boot_addrs[i]) begin
         check_read(boot_addrs[i] | BOOT_BASE, "boot ram after boot mode");
      end

      // partial writes, odd passes go to the boot RAM
      for (int i = 0; i < 12; i++) begin
         idx       = 10'($random(seed));
         test_addr = {20'b0, idx, 2'b00} | ((i % 2 == 1) ? BOOT_BASE : 32'h0);
         word      = $random(seed);
         bus_write(test_addr, word, 4'hf);
         model_write(test_addr, word, 4'hf);
         word = $random(seed);
         strb = 4'($random(seed));
         bus_write(test_addr, word, strb);
         model_write(test_addr, word, strb);
         check_read(test_addr, "byte strobe merge");
      end

      fork
         bus_write(RST_BASE, 32'h1, 4'hf);
         count_core_reset(6, pulses);
      join
      model_write(RST_BASE, 32'h1, 4'hf);
      queue_check("core_reset pulse cycles", 32'h1, data_t'(pulses));
      check_read(RST_BASE, "boot flag");
      fork
         bus_write(RST_BASE, 32'h3, 4'hf);
         count_core_reset(6, pulses);
      join
      model_write(RST_BASE, 32'h3, 4'hf);
      queue_check("core_reset pulse cycles", 32'h1, data_t'(pulses));
      check_read(RST_BASE, "boot flag");
      check_read(boot_addrs[0], "boot ram via region 0");
      bus_write(RST_BASE, 32'h0, 4'hf);
      model_write(RST_BASE, 32'h0, 4'hf);

      repeat (3) begin
         tx_byte = 8'($random(seed));
         send_byte(tx_byte, BAUD_DIV);
      end

      // second byte arrives while the first is on the line
      tx_byte = 8'($random(seed));
      fork
         uart_receive(BAUD_DIV, rx_byte);
         begin
            bus_write(TX_ADDR, {24'b0, tx_byte}, 4'hf);
            bus_read(STATUS_ADDR, read_word);
            queue_check("m_rsp.rdata uart status busy", 32'h1, read_word);
            bus_write(TX_ADDR, {24'b0, ~tx_byte}, 4'hf);
         end
      join
      queue_check("txd frame", {24'b0, tx_byte}, {24'b0, rx_byte});
      // no second frame may follow the stop bit
      line_stays_idle(3 * BAUD_DIV);
      wait_uart_idle();

      cts     = 1'b0;
      tx_byte = 8'($random(seed));
      fork
         uart_receive(BAUD_DIV, rx_byte);
         begin
            bus_write(TX_ADDR, {24'b0, tx_byte}, 4'hf);
            bus_read(STATUS_ADDR, read_word);
            queue_check("m_rsp.rdata uart status busy", 32'h1, read_word);
            line_stays_idle(3 * BAUD_DIV);
            cts = 1'b1;
         end
      join
      queue_check("txd frame", {24'b0, tx_byte}, {24'b0, rx_byte});
      wait_uart_idle();

      bus_write(DIV_ADDR, 32'h8, 4'hf);
      bus_read(DIV_ADDR, read_word);
      queue_check("m_rsp.rdata uart divisor", 32'h8, read_word);
      tx_byte = 8'($random(seed));
      send_byte(tx_byte, 8);

      // let the compare side drain
      @(posedge clk);
      @(negedge clk);
      if (act_q.size() == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         stop_on_error("reads were left unchecked at the end of the run");
      end
   end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release away from the rising edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule
